// ==== common/ps2_pkg.sv ====
package ps2_pkg;

    // Filtered bus levels plus a strobe on each falling clock edge
    typedef struct packed {
        logic clk;
        logic data;
        logic clk_fall;
    } ps2_line_t;

    // Receive check result, first failing check wins
    typedef enum logic [1:0] {
        RX_OK         = 2'd0,
        RX_ERR_START  = 2'd1,
        RX_ERR_PARITY = 2'd2,
        RX_ERR_STOP   = 2'd3
    } rx_err_e;

    // One device frame, valid for a single cycle
    typedef struct packed {
        logic [7:0] data;
        rx_err_e    err;
        logic       valid;
    } rx_frame_t;

endpackage

// ==== common/mouse_pkg.sv ====
package mouse_pkg;

    // Host to mouse commands
    typedef enum logic [7:0] {
        CMD_ENABLE_STREAM = 8'hF4,
        CMD_RESET         = 8'hFF
    } mouse_cmd_e;

    // Mouse replies seen during initialization
    typedef enum logic [7:0] {
        RESP_DEVICE_ID   = 8'h00,
        RESP_SELFTEST_OK = 8'hAA,
        RESP_ACK         = 8'hFA
    } mouse_resp_e;

    typedef enum logic [2:0] {
        ST_SEND_RESET      = 3'd0,
        ST_WAIT_RESET_RESP = 3'd1,
        ST_SEND_ENABLE     = 3'd2,
        ST_WAIT_ENABLE_ACK = 3'd3,
        ST_STREAM          = 3'd4
    } master_state_e;

    // Byte forwarded while streaming, bad marks a receive error
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       bad;
    } stream_byte_t;

    // Buttons are left, right, middle from bit 0 up
    typedef struct packed {
        logic [2:0]        buttons;
        logic              x_ovf;
        logic              y_ovf;
        logic signed [8:0] dx;
        logic signed [8:0] dy;
    } mouse_packet_t;

endpackage

// ==== ps2_phy/ps2_bus_sync.sv ====
`timescale 1ns/1ps

module ps2_bus_sync #(
    parameter int unsigned FILTER_LEN = 4
) (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               ps2_clk_in,
    input  logic               ps2_data_in,
    output ps2_pkg::ps2_line_t line
);
    localparam int CNT_W = $clog2(FILTER_LEN + 1);

    // Index 0 is the clock line, index 1 the data line
    logic [1:0]       sync_meta;
    logic [1:0]       sync_q;
    logic [1:0]       filt_q;
    logic [CNT_W-1:0] stable_cnt [2];
    logic             clk_fall_q;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            sync_meta  <= 2'b11;
            sync_q     <= 2'b11;
            filt_q     <= 2'b11;
            stable_cnt <= '{default: '0};
            clk_fall_q <= 1'b0;
        end else begin
            sync_meta  <= {ps2_data_in, ps2_clk_in};
            sync_q     <= sync_meta;
            clk_fall_q <= 1'b0;
            for (int i = 0; i < 2; i++) begin
                if (sync_q[i] == filt_q[i]) begin
                    stable_cnt[i] <= '0;
                end else if (stable_cnt[i] == CNT_W'(FILTER_LEN - 1)) begin
                    // Level held long enough, accept it
                    filt_q[i]     <= sync_q[i];
                    stable_cnt[i] <= '0;
                    if (i == 0 && !sync_q[i]) begin
                        clk_fall_q <= 1'b1;
                    end
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    assign line = '{clk: filt_q[0], data: filt_q[1], clk_fall: clk_fall_q};

endmodule

// ==== ps2_phy/ps2_rx.sv ====
`timescale 1ns/1ps

module ps2_rx (
    input  logic               CLK,
    input  logic               RESET,
    input  ps2_pkg::ps2_line_t line,
    input  logic               rx_enable,
    output ps2_pkg::rx_frame_t frame
);
    import ps2_pkg::*;

    logic [10:0] shift_q;
    logic [3:0]  bit_cnt;
    logic [10:0] full_frame;
    logic        last_bit;
    rx_err_e     check_err;
    logic [7:0]  data_q;
    rx_err_e     err_q;
    logic        valid_q;

    // Bits arrive LSB first, so the newest sample enters at the top
    assign full_frame = {line.data, shift_q[10:1]};
    assign last_bit   = rx_enable && line.clk_fall && (bit_cnt == 4'd10);

    always_comb begin
        if (full_frame[0]) begin
            check_err = RX_ERR_START;
        end else if (!(^full_frame[9:1])) begin
            check_err = RX_ERR_PARITY;
        end else if (!full_frame[10]) begin
            check_err = RX_ERR_STOP;
        end else begin
            check_err = RX_OK;
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            shift_q <= '0;
            bit_cnt <= '0;
        end else if (!rx_enable) begin
            // Held idle while the host owns the bus
            shift_q <= '0;
            bit_cnt <= '0;
        end else if (line.clk_fall) begin
            shift_q <= full_frame;
            bit_cnt <= last_bit ? 4'd0 : bit_cnt + 4'd1;
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            valid_q <= 1'b0;
            err_q   <= RX_OK;
        end else begin
            valid_q <= last_bit;
            if (last_bit) begin
                err_q <= check_err;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (last_bit) begin
            data_q <= full_frame[8:1];
        end
    end

    assign frame = '{data: data_q, err: err_q, valid: valid_q};

endmodule

// ==== ps2_phy/ps2_tx.sv ====
`timescale 1ns/1ps

module ps2_tx #(
    parameter int unsigned INHIBIT_CYCLES = 5000
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  ps2_pkg::ps2_line_t    line,
    input  logic                  tx_start,
    input  mouse_pkg::mouse_cmd_e tx_byte,
    output logic                  tx_busy,
    output logic                  tx_done,
    output logic                  tx_ack_ok,
    output logic                  clk_drive_low,
    output logic                  data_drive_low
);
    localparam int HOLD_W = $clog2(INHIBIT_CYCLES + 1);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_INHIBIT,
        TX_REQUEST,
        TX_SHIFT,
        TX_ACK
    } tx_phase_e;

    tx_phase_e         phase;
    logic [HOLD_W-1:0] hold_cnt;
    logic [3:0]        bit_cnt;
    logic [9:0]        shift_q;
    logic              data_low_q;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            phase      <= TX_IDLE;
            hold_cnt   <= '0;
            bit_cnt    <= '0;
            data_low_q <= 1'b0;
            tx_done    <= 1'b0;
            tx_ack_ok  <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (phase)
                TX_IDLE: begin
                    if (tx_start) begin
                        phase    <= TX_INHIBIT;
                        hold_cnt <= '0;
                    end
                end
                TX_INHIBIT: begin
                    // Clock held low, then request to send with data low
                    if (hold_cnt == HOLD_W'(INHIBIT_CYCLES - 1)) begin
                        phase      <= TX_REQUEST;
                        data_low_q <= 1'b1;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                TX_REQUEST: begin
                    if (line.clk_fall) begin
                        data_low_q <= ~shift_q[0];
                        bit_cnt    <= 4'd1;
                        phase      <= TX_SHIFT;
                    end
                end
                TX_SHIFT: begin
                    if (line.clk_fall) begin
                        data_low_q <= ~shift_q[0];
                        bit_cnt    <= bit_cnt + 4'd1;
                        // Stop bit goes out on this edge
                        if (bit_cnt == 4'd9) begin
                            phase <= TX_ACK;
                        end
                    end
                end
                TX_ACK: begin
                    if (line.clk_fall) begin
                        tx_done   <= 1'b1;
                        tx_ack_ok <= ~line.data;
                        phase     <= TX_IDLE;
                    end
                end
                default: phase <= TX_IDLE;
            endcase
        end
    end

    // Stop, odd parity, data LSB first
    always_ff @(posedge CLK) begin
        if (phase == TX_IDLE && tx_start) begin
            shift_q <= {1'b1, ~^tx_byte, tx_byte};
        end else if (line.clk_fall && (phase == TX_REQUEST || phase == TX_SHIFT)) begin
            shift_q <= {1'b1, shift_q[9:1]};
        end
    end

    assign tx_busy        = (phase != TX_IDLE);
    assign clk_drive_low  = (phase == TX_INHIBIT);
    assign data_drive_low = data_low_q;

endmodule

// ==== hw/mouse_master.sv ====
`timescale 1ns/1ps

module mouse_master #(
    parameter int unsigned TICKS_PER_MS    = 50000,
    parameter int unsigned RESP_TIMEOUT_MS = 20,
    parameter int unsigned WATCHDOG_MS     = 2000
) (
    input  logic                    CLK,
    input  logic                    RESET,
    input  ps2_pkg::rx_frame_t      frame,
    output logic                    rx_enable,
    output logic                    tx_start,
    output mouse_pkg::mouse_cmd_e   tx_byte,
    input  logic                    tx_busy,
    input  logic                    tx_done,
    input  logic                    tx_ack_ok,
    output mouse_pkg::stream_byte_t stream,
    output logic                    flush,
    output logic                    mouse_ready
);
    import ps2_pkg::*;
    import mouse_pkg::*;

    localparam int TICK_W = $clog2(TICKS_PER_MS + 1);
    localparam int TO_W   = $clog2(RESP_TIMEOUT_MS + 1);
    localparam int WD_W   = $clog2(WATCHDOG_MS + 1);

    master_state_e     state;
    master_state_e     next_state;
    mouse_resp_e       expected_resp;
    logic [1:0]        reply_idx;
    logic              cmd_issued;
    logic [TICK_W-1:0] tick_cnt;
    logic              ms_tick;
    logic [TO_W-1:0]   timeout_ms;
    logic [WD_W-1:0]   watchdog_ms;
    logic              frame_ok;
    logic              timed_out;
    logic              fwd_valid;
    logic              fwd_bad;
    logic [7:0]        fwd_data;

    assign frame_ok  = frame.valid && (frame.err == RX_OK);
    assign ms_tick   = (tick_cnt == TICK_W'(TICKS_PER_MS - 1));
    assign timed_out = (timeout_ms == TO_W'(RESP_TIMEOUT_MS));

    // Reset reply sequence is FA, AA, 00
    always_comb begin
        case (reply_idx)
            2'd0:    expected_resp = RESP_ACK;
            2'd1:    expected_resp = RESP_SELFTEST_OK;
            default: expected_resp = RESP_DEVICE_ID;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_SEND_RESET: begin
                if (tx_done) next_state = tx_ack_ok ? ST_WAIT_RESET_RESP : ST_SEND_RESET;
            end
            ST_WAIT_RESET_RESP: begin
                if (frame.valid) begin
                    if (!frame_ok || frame.data != expected_resp) next_state = ST_SEND_RESET;
                    else if (reply_idx == 2'd2) next_state = ST_SEND_ENABLE;
                end else if (timed_out) begin
                    next_state = ST_SEND_RESET;
                end
            end
            ST_SEND_ENABLE: begin
                if (tx_done) next_state = tx_ack_ok ? ST_WAIT_ENABLE_ACK : ST_SEND_RESET;
            end
            ST_WAIT_ENABLE_ACK: begin
                if (frame.valid) begin
                    next_state = (frame_ok && frame.data == RESP_ACK) ? ST_STREAM : ST_SEND_RESET;
                end else if (timed_out) begin
                    next_state = ST_SEND_RESET;
                end
            end
            ST_STREAM: begin
                if (watchdog_ms == WD_W'(WATCHDOG_MS)) next_state = ST_SEND_RESET;
            end
            default: next_state = ST_SEND_RESET;
        endcase
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            state       <= ST_SEND_RESET;
            reply_idx   <= '0;
            cmd_issued  <= 1'b0;
            tx_start    <= 1'b0;
            tick_cnt    <= '0;
            timeout_ms  <= '0;
            watchdog_ms <= '0;
            fwd_valid   <= 1'b0;
            fwd_bad     <= 1'b0;
            flush       <= 1'b0;
        end else begin
            state    <= next_state;
            tx_start <= 1'b0;
            tick_cnt <= ms_tick ? '0 : tick_cnt + 1'b1;

            if (state != next_state) reply_idx <= '0;
            else if (state == ST_WAIT_RESET_RESP && frame_ok) reply_idx <= reply_idx + 2'd1;

            // One command per send state, reissued after a failed acknowledge
            if (state != next_state || tx_done) begin
                cmd_issued <= 1'b0;
            end else if ((state == ST_SEND_RESET || state == ST_SEND_ENABLE) &&
                         !cmd_issued && !tx_busy) begin
                tx_start   <= 1'b1;
                cmd_issued <= 1'b1;
            end

            // Restarted by each good reply byte
            if (state != next_state || frame_ok ||
                !(state inside {ST_WAIT_RESET_RESP, ST_WAIT_ENABLE_ACK})) begin
                timeout_ms <= '0;
            end else if (ms_tick) begin
                timeout_ms <= timeout_ms + 1'b1;
            end

            if (state != ST_STREAM || next_state != ST_STREAM || frame.valid) begin
                watchdog_ms <= '0;
            end else if (ms_tick) begin
                watchdog_ms <= watchdog_ms + 1'b1;
            end

            fwd_valid <= (state == ST_STREAM) && frame.valid;
            fwd_bad   <= (frame.err != RX_OK);
            flush     <= (state == ST_STREAM) && (next_state != ST_STREAM);
        end
    end

    always_ff @(posedge CLK) begin
        if (frame.valid) begin
            fwd_data <= frame.data;
        end
    end

    assign stream      = '{data: fwd_data, valid: fwd_valid, bad: fwd_bad};
    assign tx_byte     = (state == ST_SEND_ENABLE) ? CMD_ENABLE_STREAM : CMD_RESET;
    assign rx_enable   = !(state inside {ST_SEND_RESET, ST_SEND_ENABLE});
    assign mouse_ready = (state == ST_STREAM);

endmodule

// ==== hw/mouse_packet_assembler.sv ====
`timescale 1ns/1ps

module mouse_packet_assembler (
    input  logic                     CLK,
    input  logic                     RESET,
    input  mouse_pkg::stream_byte_t  stream,
    input  logic                     flush,
    output mouse_pkg::mouse_packet_t packet,
    output logic                     packet_valid
);
    logic [1:0] byte_idx;
    logic [7:0] status_q;
    logic [7:0] dx_q;
    logic       last_byte;

    assign last_byte = stream.valid && !stream.bad && (byte_idx == 2'd2);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            byte_idx     <= '0;
            packet_valid <= 1'b0;
        end else begin
            packet_valid <= last_byte && !flush;
            if (flush || (stream.valid && stream.bad)) begin
                byte_idx <= '0;
            end else if (stream.valid) begin
                case (byte_idx)
                    // Status byte always has bit 3 set, anything else is dropped
                    2'd0:    byte_idx <= stream.data[3] ? 2'd1 : 2'd0;
                    2'd1:    byte_idx <= 2'd2;
                    default: byte_idx <= 2'd0;
                endcase
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (stream.valid && byte_idx == 2'd0) status_q <= stream.data;
        if (stream.valid && byte_idx == 2'd1) dx_q <= stream.data;
        if (last_byte) begin
            packet.buttons <= status_q[2:0];
            packet.x_ovf   <= status_q[6];
            packet.y_ovf   <= status_q[7];
            // Sign bits live in the status byte
            packet.dx      <= {status_q[4], dx_q};
            packet.dy      <= {status_q[5], stream.data};
        end
    end

endmodule

// ==== hw/ps2_mouse_top.sv ====
`timescale 1ns/1ps

module ps2_mouse_top #(
    parameter int unsigned TICKS_PER_MS    = 50000,
    parameter int unsigned RESP_TIMEOUT_MS = 20,
    parameter int unsigned WATCHDOG_MS     = 2000,
    parameter int unsigned INHIBIT_CYCLES  = 5000,
    parameter int unsigned FILTER_LEN      = 4
) (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     ps2_clk_in,
    input  logic                     ps2_data_in,
    output logic                     ps2_clk_drive_low,
    output logic                     ps2_data_drive_low,
    output mouse_pkg::mouse_packet_t packet,
    output logic                     packet_valid,
    output logic                     mouse_ready
);
    import ps2_pkg::*;
    import mouse_pkg::*;

    ps2_line_t    line;
    rx_frame_t    frame;
    stream_byte_t stream;
    mouse_cmd_e   tx_byte;
    logic         rx_enable;
    logic         tx_start;
    logic         tx_busy;
    logic         tx_done;
    logic         tx_ack_ok;
    logic         flush;

    ps2_bus_sync #(.FILTER_LEN(FILTER_LEN)) u_ps2_bus_sync (
        .CLK(CLK), .RESET(RESET), .ps2_clk_in(ps2_clk_in), .ps2_data_in(ps2_data_in),
        .line(line)
    );

    ps2_rx u_ps2_rx (
        .CLK(CLK), .RESET(RESET), .line(line), .rx_enable(rx_enable), .frame(frame)
    );

    // Transmitter hangs off the master and drives the open-drain pins
    ps2_tx #(.INHIBIT_CYCLES(INHIBIT_CYCLES)) u_ps2_tx (
        .CLK(CLK), .RESET(RESET), .line(line), .tx_start(tx_start), .tx_byte(tx_byte),
        .tx_busy(tx_busy), .tx_done(tx_done), .tx_ack_ok(tx_ack_ok),
        .clk_drive_low(ps2_clk_drive_low), .data_drive_low(ps2_data_drive_low)
    );

    mouse_master #(
        .TICKS_PER_MS(TICKS_PER_MS),
        .RESP_TIMEOUT_MS(RESP_TIMEOUT_MS),
        .WATCHDOG_MS(WATCHDOG_MS)
    ) u_mouse_master (
        .CLK(CLK), .RESET(RESET), .frame(frame), .rx_enable(rx_enable),
        .tx_start(tx_start), .tx_byte(tx_byte), .tx_busy(tx_busy), .tx_done(tx_done),
        .tx_ack_ok(tx_ack_ok), .stream(stream), .flush(flush), .mouse_ready(mouse_ready)
    );

    mouse_packet_assembler u_mouse_packet_assembler (
        .CLK(CLK), .RESET(RESET), .stream(stream), .flush(flush),
        .packet(packet), .packet_valid(packet_valid)
    );

endmodule

// ==== dv/tb_ps2_mouse.sv ====
`timescale 1ns/1ps

module tb_ps2_mouse;
    import mouse_pkg::*;

    localparam int TICKS_PER_MS = 50;
    localparam int WATCHDOG_MS  = 60;
    localparam int HALF_BIT     = 8;
    localparam int WAIT_LIMIT   = 8000;

    logic          CLK = 1'b0;
    logic          RESET;
    logic          dev_clk;
    logic          dev_data;
    logic          ps2_clk_line;
    logic          ps2_data_line;
    logic          ps2_clk_drive_low;
    logic          ps2_data_drive_low;
    mouse_packet_t packet;
    logic          packet_valid;
    logic          mouse_ready;
    bit            hold_seen;
    mouse_packet_t seen_q[$];

    // Each line is a wired-AND of host and device
    assign ps2_clk_line  = dev_clk & ~ps2_clk_drive_low;
    assign ps2_data_line = dev_data & ~ps2_data_drive_low;

    ps2_mouse_top #(
        .TICKS_PER_MS(TICKS_PER_MS),
        .RESP_TIMEOUT_MS(20),
        .WATCHDOG_MS(WATCHDOG_MS),
        .INHIBIT_CYCLES(20),
        .FILTER_LEN(4)
    ) u_ps2_mouse_top (
        .CLK(CLK), .RESET(RESET), .ps2_clk_in(ps2_clk_line), .ps2_data_in(ps2_data_line),
        .ps2_clk_drive_low(ps2_clk_drive_low), .ps2_data_drive_low(ps2_data_drive_low),
        .packet(packet), .packet_valid(packet_valid), .mouse_ready(mouse_ready)
    );

    initial begin
        forever #2 CLK = ~CLK;
    end

    // Packet capture and host clock hold detection
    always @(negedge CLK) begin
        if (packet_valid)
            seen_q.push_back(packet);
        if (ps2_clk_drive_low)
            hold_seen = 1'b1;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        if (want !== got) begin
            $display("ERR t=%0t %s expected 0x%0h got 0x%0h", $time, name, want, got);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_ready(input logic level, output int cycles);
        cycles = 0;
        while (mouse_ready !== level) begin
            @(negedge CLK);
            cycles++;
            if (cycles > WAIT_LIMIT)
                report_failure("Timeout waiting for mouse_ready to change");
        end
    endtask

    // Device frame of start bit, data LSB first, odd parity and stop
    task automatic device_send_byte(input logic [7:0] value, input bit bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^value) ^ bad_parity, value, 1'b0};
        for (int i = 0; i < 11; i++) begin
            dev_data = bits[i];
            repeat (HALF_BIT) @(negedge CLK);
            dev_clk = 1'b0;
            repeat (HALF_BIT) @(negedge CLK);
            dev_clk = 1'b1;
        end
        dev_data = 1'b1;
        repeat (4 * HALF_BIT) @(negedge CLK);
    endtask

    task automatic device_recv_cmd(input logic [7:0] want_cmd);
        logic [9:0] bits;
        int         waited;
        waited = 0;
        // Request to send is clock released with data held low
        while (ps2_clk_drive_low || !ps2_data_drive_low) begin
            @(negedge CLK);
            waited++;
            if (waited > WAIT_LIMIT)
                report_failure("Timeout waiting for the host request to send");
        end
        check_value("ps2_clk_drive_low hold", 1, hold_seen);
        repeat (2 * HALF_BIT) @(negedge CLK);
        // Host changes data after each fall and the model samples late in the high half
        for (int i = 0; i < 10; i++) begin
            dev_clk = 1'b0;
            repeat (HALF_BIT) @(negedge CLK);
            dev_clk = 1'b1;
            repeat (HALF_BIT) @(negedge CLK);
            bits[i] = ps2_data_line;
        end
        dev_data = 1'b0;
        repeat (HALF_BIT) @(negedge CLK);
        dev_clk = 1'b0;
        repeat (HALF_BIT) @(negedge CLK);
        dev_clk   = 1'b1;
        dev_data  = 1'b1;
        hold_seen = 1'b0;
        check_value("command byte", want_cmd, bits[7:0]);
        check_value("command parity", ~^want_cmd, bits[8]);
        check_value("command stop", 1, bits[9]);
        repeat (4 * HALF_BIT) @(negedge CLK);
    endtask

    function automatic mouse_packet_t expected_packet(input logic [7:0] b0,
                                                      input logic [7:0] b1,
                                                      input logic [7:0] b2);
        mouse_packet_t p;
        p.buttons = b0[2:0];
        p.x_ovf   = b0[6];
        p.y_ovf   = b0[7];
        // Deltas are nine-bit two's complement with the sign in the status byte
        p.dx      = 9'(int'(b1) - (b0[4] ? 256 : 0));
        p.dy      = 9'(int'(b2) - (b0[5] ? 256 : 0));
        return p;
    endfunction

    task automatic send_packet_and_check(input logic [7:0] b0, input logic [7:0] b1,
                                         input logic [7:0] b2);
        mouse_packet_t want;
        mouse_packet_t got;
        int            waited;
        want = expected_packet(b0, b1, b2);
        device_send_byte(b0, 1'b0);
        device_send_byte(b1, 1'b0);
        device_send_byte(b2, 1'b0);
        waited = 0;
        while (seen_q.size() == 0) begin
            @(negedge CLK);
            waited++;
            if (waited > WAIT_LIMIT)
                report_failure("Timeout waiting for packet_valid");
        end
        check_value("packet_valid count", 1, seen_q.size());
        got = seen_q.pop_front();
        check_value("packet.buttons", want.buttons, got.buttons);
        check_value("packet.x_ovf", want.x_ovf, got.x_ovf);
        check_value("packet.y_ovf", want.y_ovf, got.y_ovf);
        check_value("packet.dx", want.dx, got.dx);
        check_value("packet.dy", want.dy, got.dy);
    endtask

    // Reset reply followed by the stream enable handshake
    task automatic finish_init();
        int waited;
        device_send_byte(8'hFA, 1'b0);
        device_send_byte(8'hAA, 1'b0);
        device_send_byte(8'h00, 1'b0);
        device_recv_cmd(8'hF4);
        check_value("mouse_ready before ack", 0, mouse_ready);
        device_send_byte(8'hFA, 1'b0);
        wait_ready(1'b1, waited);
    endtask

    task automatic init_handshake();
        device_recv_cmd(8'hFF);
        finish_init();
    endtask

    task automatic decode_random_packets();
        logic [7:0] b0;
        for (int n = 0; n < 20; n++) begin
            b0    = 8'($urandom());
            b0[3] = 1'b1;
            send_packet_and_check(b0, 8'($urandom()), 8'($urandom()));
        end
    endtask

    task automatic resync_after_stray_byte();
        logic [7:0] stray;
        stray    = 8'($urandom());
        stray[3] = 1'b0;
        device_send_byte(stray, 1'b0);
        send_packet_and_check(8'h2B, 8'h80, 8'h7F);
    endtask

    task automatic drop_packet_on_bad_parity();
        device_send_byte(8'h1C, 1'b0);
        device_send_byte(8'h33, 1'b1);
        send_packet_and_check(8'hCA, 8'h05, 8'hFE);
    endtask

    task automatic restart_on_stream_silence();
        int quiet;
        wait_ready(1'b0, quiet);
        check_value("mouse_ready held", 1, quiet >= (WATCHDOG_MS - 3) * TICKS_PER_MS);
        device_recv_cmd(8'hFF);
    endtask

    // The FF just taken by the model is left unanswered
    task automatic retry_after_missing_reply();
        device_recv_cmd(8'hFF);
        finish_init();
        send_packet_and_check(8'h09, 8'h10, 8'hF0);
    endtask

    initial begin
        void'($urandom(32'h5e11_b287));
        RESET    = 1'b0;
        dev_clk  = 1'b1;
        dev_data = 1'b1;
        repeat (8) @(negedge CLK);
        check_value("mouse_ready", 0, mouse_ready);
        check_value("packet_valid", 0, packet_valid);
        check_value("ps2_clk_drive_low", 0, ps2_clk_drive_low);
        check_value("ps2_data_drive_low", 0, ps2_data_drive_low);
        RESET = 1'b1;
        init_handshake();
        decode_random_packets();
        resync_after_stray_byte();
        drop_packet_on_bad_parity();
        restart_on_stream_silence();
        retry_after_missing_reply();
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== compile.f ====
common/ps2_pkg.sv
common/mouse_pkg.sv
ps2_phy/ps2_bus_sync.sv
ps2_phy/ps2_rx.sv
ps2_phy/ps2_tx.sv
hw/mouse_master.sv
hw/mouse_packet_assembler.sv
hw/ps2_mouse_top.sv
dv/tb_ps2_mouse.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the PS/2 mouse testbench with Verilator and runs it.
# The exit status is the simulator's, nonzero when the testbench fails.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_ps2_mouse \
        -f compile.f -o tb_ps2_mouse; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_ps2_mouse; then
    echo "Simulation exited with an error"
    exit 1
fi

echo "Simulation completed"
exit 0
